/* filelist.f */
hdl/ght_pkg.sv
hdl/ght_entry.sv
hdl/ght_cam.sv
hdl/ght_history.sv
hdl/ght_lookup.sv
hdl/ght_top.sv
verification/ght_clock_gen.sv
verification/ght_checker.sv
verification/ght_tb.sv

/* verification/ght_tb.sv */
/*
  testbench top: clock, DUT, checker, the directed and random
  test sequences and the cycle-count timeout.
*/

`timescale 1ns/10ps

module ght_tb import ght_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 5000;  // six tests of at most 400 cycles, with margin.

  logic       clk, rst;
  logic       retire_valid, retire_taken, flush, lookup_valid, lookup_done;
  pc_t        retire_pc, lookup_pc;
  thread_t    retire_thread, flush_thread, lookup_thread;
  slot_hits_t lookup_hits;

  ght_hist_t  hist_trk [NUM_THREADS];  // stimulus side view of the histories.
  ght_index_t wr_idx [$];
  thread_t    wr_thr [$];
  int         cycle_count = 0;

  ght_clock_gen clock_inst (.clk, .rst);

  ght_top ght_top_inst (
    .clk, .rst,
    .retire_valid, .retire_pc, .retire_taken, .retire_thread,
    .flush, .flush_thread,
    .lookup_valid, .lookup_pc, .lookup_thread,
    .lookup_done, .lookup_hits
  );

  ght_checker check_inst (
    .clk, .rst,
    .retire_valid, .retire_pc, .retire_taken, .retire_thread,
    .flush, .flush_thread,
    .lookup_valid, .lookup_pc, .lookup_thread,
    .lookup_done, .lookup_hits
  );

  // one clock of stimulus; also records written keys for targeted lookups.
  task automatic cycle(input logic rv, input pc_t rpc, input logic rtk, input thread_t rth,
                       input logic fl, input thread_t fth,
                       input logic lv, input pc_t lpc, input thread_t lth);
    @(posedge clk);
    retire_valid  <= rv;
    retire_pc     <= rpc;
    retire_taken  <= rtk;
    retire_thread <= rth;
    flush         <= fl;
    flush_thread  <= fth;
    lookup_valid  <= lv;
    lookup_pc     <= lpc;
    lookup_thread <= lth;
    if (rv && rtk && !(fl && (fth == rth))) begin
      wr_idx.push_back(ght_hash(rpc, hist_trk[rth]));
      wr_thr.push_back(rth);
      if (wr_idx.size() > 128) begin
        void'(wr_idx.pop_front());
        void'(wr_thr.pop_front());
      end
    end
    for (int t = 0; t < NUM_THREADS; t++) begin
      if (fl && (fth == thread_t'(t))) hist_trk[t] = '0;
      else if (rv && (rth == thread_t'(t))) hist_trk[t] = {hist_trk[t][GHT_INDEX_W-2:0], rtk};
    end
  endtask

  task automatic idle(input int n);
    repeat (n) cycle(1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, 1'b0);
  endtask

  // block address whose slot hashes to idx under the thread's current history.
  function automatic pc_t target_pc(input ght_index_t idx, input thread_t th);
    pc_t pc;
    int  slot;
    slot = $urandom_range(LOOKUP_SLOTS - 1, 0);
    pc = $urandom;
    pc[GHT_INDEX_W+1:2] = idx ^ hist_trk[th];
    pc[1:0] = 2'b00;
    return pc - pc_t'(slot * SLOT_BYTES);
  endfunction

  task automatic do_lookup(input pc_t pc, input thread_t th);
    int n;
    cycle(1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, pc, th);
    idle(1);
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while ((lookup_done !== 1'b1) && (n < 4));  // bounded wait for the result strobe.
  endtask

  task automatic lookup_written_from(input int first);
    for (int i = first; i < wr_idx.size(); i++) begin
      do_lookup(target_pc(wr_idx[i], wr_thr[i]), wr_thr[i]);
    end
  endtask

  initial begin : run_tests
    int          sz0;
    int          k;
    logic        rv, rtk, fl, lv;
    thread_t     rth, fth, lth;
    pc_t         lpc;
    pc_t         rpc;
    ght_index_t  key;
    void'($urandom(32'h7468_fc08));
    retire_valid = 1'b0;
    retire_pc = '0;
    retire_taken = 1'b0;
    retire_thread = 1'b0;
    flush = 1'b0;
    flush_thread = 1'b0;
    lookup_valid = 1'b0;
    lookup_pc = '0;
    lookup_thread = 1'b0;
    hist_trk[0] = '0;
    hist_trk[1] = '0;
    wait (rst === 1'b0);

    check_inst.begin_test("reset_state");
    idle(2);
    repeat (6) do_lookup($urandom, thread_t'($urandom_range(1, 0)));
    idle(2);
    check_inst.end_test();

    check_inst.begin_test("learn_hit");
    sz0 = wr_idx.size();
    repeat (30) begin
      cycle(1'b1, $urandom, ($urandom_range(3, 0) != 0), 1'b0, 1'b0, 1'b0, 1'b0, '0, 1'b0);
    end
    idle(1);
    lookup_written_from(sz0);
    idle(2);
    check_inst.end_test();

    check_inst.begin_test("round_robin");
    sz0 = wr_idx.size();
    repeat (40) cycle(1'b1, $urandom, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, '0, 1'b0);
    idle(1);
    lookup_written_from(sz0);  // first eight were overwritten.
    idle(2);
    check_inst.end_test();

    check_inst.begin_test("thread_flush");
    sz0 = wr_idx.size();
    for (int i = 0; i < 20; i++) begin
      cycle(1'b1, $urandom, 1'b1, thread_t'(i % 2), 1'b0, 1'b0, 1'b0, '0, 1'b0);
    end
    cycle(1'b0, '0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, '0, 1'b0);
    idle(1);
    lookup_written_from(sz0);
    sz0 = wr_idx.size();
    repeat (4) cycle(1'b1, $urandom, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, '0, 1'b0);
    lookup_written_from(sz0);  // history of thread 0 restarted from zero.
    idle(2);
    check_inst.end_test();

    check_inst.begin_test("collisions");
    // a flush of the same thread drops the write.
    rpc = $urandom;
    key = ght_hash(rpc, hist_trk[0]);
    cycle(1'b1, rpc, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, '0, 1'b0);
    // other-thread flush keeps its write while the dropped key is probed.
    lpc = target_pc(key, 1'b0);
    cycle(1'b1, $urandom, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, lpc, 1'b0);
    lpc = target_pc(wr_idx[wr_idx.size()-1], 1'b1);
    cycle(1'b1, $urandom, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, lpc, 1'b1);
    cycle(1'b1, $urandom, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, '0, 1'b0);
    lpc = target_pc(wr_idx[wr_idx.size()-1], 1'b0);
    cycle(1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, lpc, 1'b0);  // visible one edge later.
    for (int i = 0; i < 4; i++) begin
      k = wr_idx.size() - 1 - i;
      cycle(1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, target_pc(wr_idx[k], wr_thr[k]), wr_thr[k]);
    end
    idle(3);
    check_inst.end_test();

    check_inst.begin_test("random_mix");
    repeat (300) begin
      rv  = $urandom_range(1, 0);
      rtk = ($urandom_range(4, 0) < 3);
      rth = thread_t'($urandom_range(1, 0));
      fl  = ($urandom_range(31, 0) == 0);
      fth = thread_t'($urandom_range(1, 0));
      lv  = $urandom_range(1, 0);
      lth = thread_t'($urandom_range(1, 0));
      lpc = $urandom;
      if (lv && (wr_idx.size() != 0) && $urandom_range(1, 0)) begin
        k   = $urandom_range(wr_idx.size() - 1, 0);
        lth = wr_thr[k];
        lpc = target_pc(wr_idx[k], lth);
      end
      cycle(rv, $urandom, rtk, rth, fl, fth, lv, lpc, lth);
    end
    idle(3);
    check_inst.end_test();

    check_inst.report_counts();
    if (check_inst.error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run stopped, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

endmodule

/* verification/ght_checker.sv */
/*
  reference model of both histories and the 32 CAM entries,
  lookup result and handshake checks, per-test and closing reports.
*/

`timescale 1ns/10ps

module ght_checker import ght_pkg::*; (
  input logic       clk,
  input logic       rst,
  input logic       retire_valid,
  input pc_t        retire_pc,
  input logic       retire_taken,
  input thread_t    retire_thread,
  input logic       flush,
  input thread_t    flush_thread,
  input logic       lookup_valid,
  input pc_t        lookup_pc,
  input thread_t    lookup_thread,
  input logic       lookup_done,
  input slot_hits_t lookup_hits
);

  ght_hist_t  m_hist  [NUM_THREADS];
  logic       m_valid [GHT_ENTRIES];
  thread_t    m_owner [GHT_ENTRIES];
  ght_index_t m_index [GHT_ENTRIES];
  int         m_ptr;
  logic       pending = 1'b0;  // a lookup was sampled at the previous edge.
  slot_hits_t exp_hits;
  string      test_name = "none";
  int         test_errs = 0;
  int         error_count = 0;
  int         check_count = 0;
  int         test_count = 0;
  int         failed_tests = 0;

  // hits for one fetch block from the model state before this edge.
  function automatic slot_hits_t predict(input pc_t pc, input thread_t th);
    slot_hits_t hits;
    ght_index_t key;
    hits = '0;
    for (int s = 0; s < LOOKUP_SLOTS; s++) begin
      key = ght_hash(pc + pc_t'(s * SLOT_BYTES), m_hist[th]);
      for (int e = 0; e < GHT_ENTRIES; e++) begin
        if (m_valid[e] && (m_index[e] == key)) hits[s] = 1'b1;
      end
    end
    return hits;
  endfunction

  task automatic note_error(input string msg);
    $display("%s", msg);
    test_errs++;
    error_count++;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    @(negedge clk);  // after this edge's comparisons.
    test_count++;
    if (test_errs != 0) failed_tests++;
    $display("test %-14s %s, %0d errors", test_name, (test_errs == 0) ? "ok" : "FAILED",
             test_errs);
  endtask

  task automatic report_counts();
    $display("tests run %0d, tests failed %0d, lookups checked %0d, errors %0d",
             test_count, failed_tests, check_count, error_count);
  endtask

  always @(posedge clk) begin : model_step
    logic       wen;
    ght_index_t widx;
    if (rst) begin
      for (int t = 0; t < NUM_THREADS; t++) m_hist[t] = '0;
      for (int e = 0; e < GHT_ENTRIES; e++) m_valid[e] = 1'b0;
      m_ptr   = 0;
      pending = 1'b0;
    end else begin
      // outputs seen here were set at the previous edge.
      if (pending && (lookup_done !== 1'b1)) begin
        note_error($sformatf("%s: lookup_done missing one cycle after a lookup", test_name));
      end else if (!pending && (lookup_done !== 1'b0)) begin
        note_error($sformatf("%s: lookup_done raised with no lookup the cycle before",
                             test_name));
      end else if (pending) begin
        check_count++;
        if (lookup_hits !== exp_hits) begin
          note_error($sformatf("ERR %s: lookup_hits expected %b, actual %b",
                               test_name, exp_hits, lookup_hits));
        end
      end
      pending = lookup_valid;
      if (lookup_valid) exp_hits = predict(lookup_pc, lookup_thread);

      wen  = retire_valid && retire_taken && !(flush && (flush_thread == retire_thread));
      widx = ght_hash(retire_pc, m_hist[retire_thread]);  // history before the shift.
      for (int e = 0; e < GHT_ENTRIES; e++) begin
        if (flush && m_valid[e] && (m_owner[e] == flush_thread)) begin
          m_valid[e] = 1'b0;  // flush beats a write into its own entry.
        end else if (wen && (e == m_ptr)) begin
          m_valid[e] = 1'b1;
          m_owner[e] = retire_thread;
          m_index[e] = widx;
        end
      end
      if (wen) m_ptr = (m_ptr + 1) % GHT_ENTRIES;
      for (int t = 0; t < NUM_THREADS; t++) begin
        if (flush && (flush_thread == thread_t'(t))) begin
          m_hist[t] = '0;
        end else if (retire_valid && (retire_thread == thread_t'(t))) begin
          m_hist[t] = {m_hist[t][GHT_INDEX_W-2:0], retire_taken};
        end
      end
    end
  end

endmodule

/* verification/ght_clock_gen.sv */
/*
  testbench clock (8 ns period) and power-on reset held for 5 cycles.
*/

`timescale 1ns/10ps

module ght_clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // half period.
  end

  initial begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;  // released on a rising edge like the other inputs.
  end

endmodule

/* hdl/ght_top.sv */
/*
  top level of the taken-branch tracker: history unit feeding
  the CAM, lookup unit probing it.
*/

`timescale 1ns/10ps

module ght_top import ght_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       retire_valid,
  input  pc_t        retire_pc,
  input  logic       retire_taken,
  input  thread_t    retire_thread,
  input  logic       flush,
  input  thread_t    flush_thread,
  input  logic       lookup_valid,
  input  pc_t        lookup_pc,
  input  thread_t    lookup_thread,
  output logic       lookup_done,
  output slot_hits_t lookup_hits
);

  logic       write_wen;
  ght_index_t write_index;
  thread_t    write_thread;
  ght_hist_t  hist0;
  ght_hist_t  hist1;
  ght_index_t probe_index0, probe_index1, probe_index2, probe_index3;
  logic       probe_hit0, probe_hit1, probe_hit2, probe_hit3;

  ght_history history_inst (
    .clk, .rst,
    .retire_valid, .retire_pc, .retire_taken, .retire_thread,
    .flush, .flush_thread,
    .write_wen, .write_index, .write_thread,
    .hist0, .hist1
  );

  ght_cam cam_inst (
    .clk, .rst,
    .write_wen, .write_index, .write_thread,
    .flush, .flush_thread,
    .probe_index0, .probe_index1, .probe_index2, .probe_index3,
    .probe_hit0, .probe_hit1, .probe_hit2, .probe_hit3
  );

  ght_lookup lookup_inst (
    .clk, .rst,
    .lookup_valid, .lookup_pc, .lookup_thread,
    .hist0, .hist1,
    .probe_index0, .probe_index1, .probe_index2, .probe_index3,
    .probe_hit0, .probe_hit1, .probe_hit2, .probe_hit3,
    .lookup_done, .lookup_hits
  );

endmodule

/* hdl/ght_lookup.sv */
/*
  fetch-block lookup: expands the block into slot addresses,
  hashes each with the thread history and registers the hits.
*/

`timescale 1ns/10ps

module ght_lookup import ght_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       lookup_valid,
  input  pc_t        lookup_pc,
  input  thread_t    lookup_thread,
  input  ght_hist_t  hist0,
  input  ght_hist_t  hist1,
  output ght_index_t probe_index0,
  output ght_index_t probe_index1,
  output ght_index_t probe_index2,
  output ght_index_t probe_index3,
  input  logic       probe_hit0,
  input  logic       probe_hit1,
  input  logic       probe_hit2,
  input  logic       probe_hit3,
  output logic       lookup_done,
  output slot_hits_t lookup_hits
);

  ght_hist_t  hist_sel;
  pc_t        slot_pc  [LOOKUP_SLOTS];
  ght_index_t slot_idx [LOOKUP_SLOTS];
  slot_hits_t probe_hits;

  assign hist_sel = lookup_thread ? hist1 : hist0;

  // consecutive slots of the fetch block.
  always_comb begin
    for (int s = 0; s < LOOKUP_SLOTS; s++) begin
      slot_pc[s]  = lookup_pc + pc_t'(s * SLOT_BYTES);
      slot_idx[s] = ght_hash(slot_pc[s], hist_sel);
    end
  end

  assign probe_index0 = slot_idx[0];
  assign probe_index1 = slot_idx[1];
  assign probe_index2 = slot_idx[2];
  assign probe_index3 = slot_idx[3];

  assign probe_hits = {probe_hit3, probe_hit2, probe_hit1, probe_hit0};  // slot 0 in bit 0.

  // one-cycle result, no back-pressure.
  always_ff @(posedge clk) begin
    if (rst) begin
      lookup_done <= 1'b0;
    end else begin
      lookup_done <= lookup_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (lookup_valid) begin
      lookup_hits <= probe_hits;  // state before this edge's updates.
    end
  end

endmodule

/* hdl/ght_history.sv */
/*
  per-thread global history registers and generation of the
  CAM write from retired taken branches.
*/

`timescale 1ns/10ps

module ght_history import ght_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       retire_valid,
  input  pc_t        retire_pc,
  input  logic       retire_taken,
  input  thread_t    retire_thread,
  input  logic       flush,
  input  thread_t    flush_thread,
  output logic       write_wen,
  output ght_index_t write_index,
  output thread_t    write_thread,
  output ght_hist_t  hist0,
  output ght_hist_t  hist1
);

  ght_hist_t hist_q [NUM_THREADS];
  ght_hist_t cur_hist;
  logic      flush_same;

  // history of the retiring thread, before this edge's shift.
  assign cur_hist = hist_q[retire_thread];

  assign flush_same = flush && (flush_thread == retire_thread);

  // the CAM key uses the history as seen by the branch itself.
  assign write_index  = ght_hash(retire_pc, cur_hist);
  assign write_thread = retire_thread;
  assign write_wen    = retire_valid && retire_taken && !flush_same;

  /*
    a flush clears its thread and drops any retire from that
    thread in the same cycle. the other thread keeps shifting.
  */
  always_ff @(posedge clk) begin
    for (int t = 0; t < NUM_THREADS; t++) begin
      if (rst || (flush && (flush_thread == thread_t'(t)))) begin
        hist_q[t] <= '0;
      end else if (retire_valid && (retire_thread == thread_t'(t))) begin
        hist_q[t] <= {hist_q[t][GHT_INDEX_W-2:0], retire_taken};  // newest in bit 0.
      end
    end
  end

  assign hist0 = hist_q[0];
  assign hist1 = hist_q[1];

endmodule

/* hdl/ght_cam.sv */
/*
  taken-branch index CAM: entry array, round-robin write pointer
  and the OR reduction of per-entry hits for each probe slot.
*/

`timescale 1ns/10ps

module ght_cam import ght_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       write_wen,
  input  ght_index_t write_index,
  input  thread_t    write_thread,
  input  logic       flush,
  input  thread_t    flush_thread,
  input  ght_index_t probe_index0,
  input  ght_index_t probe_index1,
  input  ght_index_t probe_index2,
  input  ght_index_t probe_index3,
  output logic       probe_hit0,
  output logic       probe_hit1,
  output logic       probe_hit2,
  output logic       probe_hit3
);

  logic [GHT_ENTRIES-1:0] wr_ptr;  // one-hot, oldest entry.
  logic [GHT_ENTRIES-1:0] hit0_way;
  logic [GHT_ENTRIES-1:0] hit1_way;
  logic [GHT_ENTRIES-1:0] hit2_way;
  logic [GHT_ENTRIES-1:0] hit3_way;

  // pointer rotates on every write, flushes leave it alone.
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= GHT_ENTRIES'(1);
    end else if (write_wen) begin
      wr_ptr <= {wr_ptr[GHT_ENTRIES-2:0], wr_ptr[GHT_ENTRIES-1]};
    end
  end

  for (genvar e = 0; e < GHT_ENTRIES; e++) begin : g_entry
    ght_entry entry_inst (
      .clk          (clk),
      .rst          (rst),
      .wen          (write_wen && wr_ptr[e]),
      .write_index  (write_index),
      .write_thread (write_thread),
      .flush        (flush),
      .flush_thread (flush_thread),
      .probe_index0 (probe_index0),
      .probe_index1 (probe_index1),
      .probe_index2 (probe_index2),
      .probe_index3 (probe_index3),
      .hit0         (hit0_way[e]),
      .hit1         (hit1_way[e]),
      .hit2         (hit2_way[e]),
      .hit3         (hit3_way[e])
    );
  end

  assign probe_hit0 = |hit0_way;
  assign probe_hit1 = |hit1_way;
  assign probe_hit2 = |hit2_way;
  assign probe_hit3 = |hit3_way;

endmodule

/* hdl/ght_entry.sv */
/*
  one CAM entry: valid flag, owning thread and stored index,
  compared against four probe keys at once.
*/

`timescale 1ns/10ps

module ght_entry import ght_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       wen,
  input  ght_index_t write_index,
  input  thread_t    write_thread,
  input  logic       flush,
  input  thread_t    flush_thread,
  input  ght_index_t probe_index0,
  input  ght_index_t probe_index1,
  input  ght_index_t probe_index2,
  input  ght_index_t probe_index3,
  output logic       hit0,
  output logic       hit1,
  output logic       hit2,
  output logic       hit3
);

  logic       valid;
  thread_t    owner;
  ght_index_t index;
  logic       flush_own;

  // only a live entry can be claimed by a flush.
  assign flush_own = valid && flush && (flush_thread == owner);

  always_ff @(posedge clk) begin
    if (rst || flush_own) begin
      valid <= 1'b0;  // flush wins over a same-cycle write.
    end else if (wen) begin
      valid <= 1'b1;
      owner <= write_thread;
      index <= write_index;
    end
  end

  assign hit0 = valid && (index == probe_index0);
  assign hit1 = valid && (index == probe_index1);
  assign hit2 = valid && (index == probe_index2);
  assign hit3 = valid && (index == probe_index3);

endmodule

/* hdl/ght_pkg.sv */
/*
  shared widths, counts and key types for the global history tracker,
  plus the index hash used by the history and lookup units.
*/

package ght_pkg;

  localparam int GHT_ENTRIES  = 32;  // CAM depth.
  localparam int GHT_INDEX_W  = 13;  // key and history width.
  localparam int LOOKUP_SLOTS = 4;   // instruction slots per fetch block.
  localparam int SLOT_BYTES   = 4;   // slot stride.
  localparam int PC_W         = 32;
  localparam int NUM_THREADS  = 2;

  typedef logic [GHT_INDEX_W-1:0]  ght_index_t;
  typedef logic [GHT_INDEX_W-1:0]  ght_hist_t;   // newest outcome in bit 0.
  typedef logic [PC_W-1:0]         pc_t;
  typedef logic                    thread_t;
  typedef logic [LOOKUP_SLOTS-1:0] slot_hits_t;

  // word address bits folded with the thread's history.
  function automatic ght_index_t ght_hash(input pc_t addr, input ght_hist_t hist);
    ght_index_t idx;
    idx = addr[GHT_INDEX_W+1:2] ^ hist;
    return idx;
  endfunction

endpackage
